// ==== sprite_config.svh ====
// Sprite generator sizes and memory address widths shared by the RTL
`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// Entries in the sprite table
// One y byte and two vram words per entry
`define SPRITE_COUNT 32

// Sprite height and width in pixels
// Also the number of pixels drawn per matching sprite
`define SPRITE_SIZE 16

// Word address width of the code and attribute memory
// 16-bit words, lower lane = code, upper lane = flags
`define VRAM_AW 12

// Address width of the byte-wide vertical position memory
// Only 0x000-0x2FF reachable from the CPU
`define YRAM_AW 10

`endif

// ==== sprite_pkg.sv ====
// Shared vector types and scanner state encoding for the sprite generator
`include "sprite_config.svh"

package sprite_pkg;

    // CPU bus
    typedef logic [12:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;

    // Code and attribute memory, 16-bit words
    typedef logic [15:0]          vram_word_t;
    typedef logic [`VRAM_AW-1:0]  vram_addr_t;

    // Vertical position memory address
    typedef logic [`YRAM_AW-1:0]  yram_addr_t;

    // Screen positions (hdump, vdump, sprite x)
    typedef logic [8:0]  scr_pos_t;

    // Tile number within the graphics ROM
    typedef logic [12:0] sprite_code_t;

    // Graphics ROM bus
    // Address = code, row, half
    typedef logic [17:0] rom_addr_t;
    typedef logic [31:0] rom_word_t;

    // Colour data
    typedef logic [4:0]  pal_t;
    // Palette above the 4-bit pixel
    typedef logic [8:0]  col_t;

    // Scanner FSM
    typedef enum logic [2:0] {
        st_idle,
        st_read_y,
        st_read_code,
        st_read_attr,
        st_fetch,
        st_draw,
        st_next
    } scan_state_t;

endpackage

// ==== sprite_cpu_decode.sv ====
// CPU bus decode with sprite table memories, configuration bytes and read-back mux
`include "sprite_config.svh"

module sprite_cpu_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_rnw,
    input  logic                   vram_cs,
    input  logic                   vctrl_cs,
    input  sprite_pkg::cpu_addr_t  cpu_addr,
    input  sprite_pkg::byte_t      cpu_dout,
    output sprite_pkg::byte_t      cpu_din,
    input  sprite_pkg::vram_addr_t scan_addr,
    output sprite_pkg::vram_word_t scan_vram,
    output sprite_pkg::byte_t      scan_y,
    output logic                   flip
);
    import sprite_pkg::*;

    localparam int VRAM_DEPTH = 1 << `VRAM_AW;
    localparam int YRAM_DEPTH = 1 << `YRAM_AW;

    // Sprite table storage
    vram_word_t vram [0:VRAM_DEPTH-1];
    byte_t      yram [0:YRAM_DEPTH-1];

    // Configuration bytes, only cfg[0] bit 6 drives logic
    byte_t      cfg [0:3];

    // CPU port read data
    vram_word_t vram_q;
    byte_t      yram_q;

    logic       yram_sel;
    logic       cfg_sel;
    logic [1:0] vram_we;
    logic       yram_we;
    logic       cfg_we;
    vram_addr_t vram_cpu_addr;
    yram_addr_t yram_cpu_addr;
    yram_addr_t yram_scan_addr;

    // Registered read selects, cpu_din follows one cycle later
    logic       rd_vctrl;
    logic       rd_cfg;
    logic       rd_upper;
    logic [1:0] rd_cfg_idx;

    assign vram_cpu_addr  = cpu_addr[`VRAM_AW-1:0];
    assign yram_cpu_addr  = cpu_addr[`YRAM_AW-1:0];
    assign yram_scan_addr = scan_addr[`YRAM_AW-1:0];

    // 0x000-0x2FF position bytes
    assign yram_sel = vctrl_cs && (cpu_addr[11:8] < 4'd3);
    // 0x300-0x303 configuration bytes
    assign cfg_sel  = vctrl_cs && (cpu_addr[11:2] == 10'h0c0);

    // Bit 12 picks the byte lane
    assign vram_we = {2{vram_cs & ~cpu_rnw}} & {cpu_addr[12], ~cpu_addr[12]};
    assign yram_we = yram_sel & ~cpu_rnw;
    assign cfg_we  = cfg_sel & ~cpu_rnw;

    assign flip = cfg[0][6];

    // Configuration registers and read selects
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg[0]     <= '0;
            cfg[1]     <= '0;
            cfg[2]     <= '0;
            cfg[3]     <= '0;
            rd_vctrl   <= 1'b0;
            rd_cfg     <= 1'b0;
            rd_upper   <= 1'b0;
            rd_cfg_idx <= '0;
        end else begin
            if (cfg_we) begin
                cfg[cpu_addr[1:0]] <= cpu_dout;
            end
            rd_vctrl   <= vctrl_cs;
            rd_cfg     <= cfg_sel;
            rd_upper   <= cpu_addr[12];
            rd_cfg_idx <= cpu_addr[1:0];
        end
    end

    // Code and attribute memory
    // CPU port with byte lanes, scanner port read only
    always_ff @(posedge clk) begin
        if (vram_we[0]) begin
            vram[vram_cpu_addr][7:0] <= cpu_dout;
        end
        if (vram_we[1]) begin
            vram[vram_cpu_addr][15:8] <= cpu_dout;
        end
        vram_q    <= vram[vram_cpu_addr];
        scan_vram <= vram[scan_addr];
    end

    // Vertical position memory
    always_ff @(posedge clk) begin
        if (yram_we) begin
            yram[yram_cpu_addr] <= cpu_dout;
        end
        yram_q <= yram[yram_cpu_addr];
        scan_y <= yram[yram_scan_addr];
    end

    // Read-back mux from the registered selects
    always_comb begin
        if (rd_cfg) begin
            cpu_din = cfg[rd_cfg_idx];
        end else if (rd_vctrl) begin
            cpu_din = yram_q;
        end else if (rd_upper) begin
            cpu_din = vram_q[15:8];
        end else begin
            cpu_din = vram_q[7:0];
        end
    end

endmodule

// ==== sprite_scan.sv ====
// Sprite scanner that walks the sprite table each line and draws into the line buffer
`include "sprite_config.svh"

module sprite_scan (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hs,
    input  sprite_pkg::scr_pos_t   vdump,
    output sprite_pkg::vram_addr_t scan_addr,
    input  sprite_pkg::vram_word_t scan_vram,
    input  sprite_pkg::byte_t      scan_y,
    output sprite_pkg::rom_addr_t  rom_addr,
    input  sprite_pkg::rom_word_t  rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output logic                   line_we,
    output sprite_pkg::scr_pos_t   line_addr,
    output sprite_pkg::col_t       line_din
);
    import sprite_pkg::*;

    localparam int IDX_W = $clog2(`SPRITE_COUNT);
    localparam int ROW_W = $clog2(`SPRITE_SIZE);
    // Attribute words sit at 0x200 + n
    localparam vram_addr_t ATTR_BASE = vram_addr_t'(12'h200);

    scan_state_t  state;
    logic         hs_l;
    logic         hs_rise;
    logic [IDX_W-1:0] idx;
    logic [ROW_W-1:0] cnt;
    logic         half;
    logic         half_sel;
    logic         match_q;

    // Sprite data latched during the walk
    byte_t        line_q;
    byte_t        ydiff;
    logic [ROW_W-1:0] row_q;
    logic [ROW_W-1:0] row_eff;
    sprite_code_t code_q;
    logic         xflip_q;
    logic         yflip_q;
    scr_pos_t     xpos_q;
    pal_t         pal_q;

    // Both ROM words of the row with pixel p in bits 4p+3..4p
    logic [4*`SPRITE_SIZE-1:0] pix;
    logic [ROW_W-1:0] pix_sel;
    logic [3:0]   pixel;

    assign hs_rise = hs & ~hs_l;

    // Rows below the sprite top modulo 256
    assign ydiff = line_q - scan_y;

    // Mirrored row and half when flipped
    assign row_eff  = row_q ^ {ROW_W{yflip_q}};
    assign half_sel = half ^ xflip_q;
    assign rom_addr = {code_q, row_eff, half_sel};

    // Reverse pixel order for xflip
    assign pix_sel = xflip_q ? ~cnt : cnt;
    assign pixel   = pix[{pix_sel, 2'b00} +: 4];

    // Table address per state
    always_comb begin
        case (state)
            st_idle, st_read_y, st_read_code: scan_addr = vram_addr_t'(idx);
            default: scan_addr = ATTR_BASE | vram_addr_t'(idx);
        endcase
    end

    // FSM and strobes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hs_l    <= 1'b0;
            state   <= st_idle;
            idx     <= '0;
            cnt     <= '0;
            half    <= 1'b0;
            match_q <= 1'b0;
            rom_cs  <= 1'b0;
            line_we <= 1'b0;
        end else begin
            hs_l    <= hs;
            line_we <= 1'b0;
            if (hs_rise) begin
                // New line restarts the walk from sprite 0
                state  <= st_read_y;
                idx    <= '0;
                rom_cs <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        state <= st_idle;
                    end
                    st_read_y: begin
                        state <= st_read_code;
                    end
                    st_read_code: begin
                        // y byte valid now
                        match_q <= ydiff < `SPRITE_SIZE;
                        state   <= st_read_attr;
                    end
                    st_read_attr: begin
                        half  <= 1'b0;
                        state <= match_q ? st_fetch : st_next;
                    end
                    st_fetch: begin
                        if (!rom_cs) begin
                            rom_cs <= 1'b1;
                        end else if (rom_ok) begin
                            // Drop the request for at least a cycle
                            rom_cs <= 1'b0;
                            half   <= 1'b1;
                            if (half) begin
                                cnt   <= '0;
                                state <= st_draw;
                            end
                        end
                    end
                    st_draw: begin
                        // Transparent pixels leave the buffer alone
                        line_we <= pixel != 4'd0;
                        cnt     <= cnt + 1'b1;
                        if (cnt == ROW_W'(`SPRITE_SIZE - 1)) begin
                            state <= st_next;
                        end
                    end
                    st_next: begin
                        if (idx == IDX_W'(`SPRITE_COUNT - 1)) begin
                            state <= st_idle;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= st_read_y;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // Sprite data and pixel path
    always_ff @(posedge clk) begin
        if (hs_rise) begin
            // Draw the line after the current one
            line_q <= vdump[7:0] + 8'd1;
        end
        case (state)
            st_read_code: begin
                row_q <= ydiff[ROW_W-1:0];
            end
            st_read_attr: begin
                // Code word arrives here
                code_q  <= scan_vram[12:0];
                xflip_q <= scan_vram[15];
                yflip_q <= scan_vram[14];
            end
            st_fetch: begin
                if (!rom_cs && !half) begin
                    // Attribute word on the first fetch cycle
                    xpos_q <= {scan_vram[8], scan_vram[7:0]};
                    pal_q  <= scan_vram[15:11];
                end
                if (rom_cs && rom_ok) begin
                    if (half_sel) begin
                        pix[63:32] <= rom_data;
                    end else begin
                        pix[31:0] <= rom_data;
                    end
                end
            end
            st_draw: begin
                // Wraps modulo 512
                line_addr <= xpos_q + scr_pos_t'(cnt);
                line_din  <= {pal_q, pixel};
            end
        endcase
    end

endmodule

// ==== sprite_line_buffer.sv ====
// Double line buffer with drawing into one half while the other is displayed and erased
module sprite_line_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hs,
    input  logic                 flip,
    input  logic                 line_we,
    input  sprite_pkg::scr_pos_t line_addr,
    input  sprite_pkg::col_t     line_din,
    input  sprite_pkg::scr_pos_t hdump,
    input  logic                 pxl_cen,
    output sprite_pkg::col_t     col_addr
);
    import sprite_pkg::*;

    localparam int HALF_AW = $bits(scr_pos_t);
    localparam int DEPTH   = 2 << HALF_AW;

    // Both halves in one array, MSB of the address picks the half
    col_t buf_mem [0:DEPTH-1];

    // Half being drawn, the other one is on screen
    logic     bank;
    logic     hs_l;
    scr_pos_t rd_addr;
    logic [HALF_AW:0] wr_idx;
    logic [HALF_AW:0] rd_idx;

    // Mirror only the read side
    // 255 - hdump in the low byte
    assign rd_addr = flip ? {hdump[8], ~hdump[7:0]} : hdump;

    assign wr_idx = {bank, line_addr};
    assign rd_idx = {~bank, rd_addr};

    // Swap halves on the hs rising edge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hs_l <= 1'b0;
            bank <= 1'b0;
        end else begin
            hs_l <= hs;
            if (hs && !hs_l) begin
                bank <= ~bank;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            buf_mem[wr_idx] <= line_din;
        end
        if (pxl_cen) begin
            // Read then clear, ready for the next draw into this half
            col_addr        <= buf_mem[rd_idx];
            buf_mem[rd_idx] <= '0;
        end
    end

endmodule

// ==== sprite_gfx.sv ====
// Sprite generator top with CPU decode, table scanner and line buffer
module sprite_gfx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  hs,
    input  sprite_pkg::scr_pos_t  vdump,
    input  sprite_pkg::scr_pos_t  hdump,
    input  logic                  cpu_rnw,
    input  sprite_pkg::cpu_addr_t cpu_addr,
    input  sprite_pkg::byte_t     cpu_dout,
    input  logic                  vram_cs,
    input  logic                  vctrl_cs,
    output sprite_pkg::byte_t     cpu_din,
    output sprite_pkg::rom_addr_t rom_addr,
    input  sprite_pkg::rom_word_t rom_data,
    input  logic                  rom_ok,
    output logic                  rom_cs,
    output logic                  flip,
    output sprite_pkg::col_t      col_addr
);
    import sprite_pkg::*;

    // Scanner access to the sprite table
    vram_addr_t scan_addr;
    vram_word_t scan_vram;
    byte_t      scan_y;

    // Pixel writes into the line buffer
    logic       line_we;
    scr_pos_t   line_addr;
    col_t       line_din;

    sprite_cpu_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cpu_rnw   (cpu_rnw),
        .vram_cs   (vram_cs),
        .vctrl_cs  (vctrl_cs),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_din   (cpu_din),
        .scan_addr (scan_addr),
        .scan_vram (scan_vram),
        .scan_y    (scan_y),
        .flip      (flip)
    );

    sprite_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .hs        (hs),
        .vdump     (vdump),
        .scan_addr (scan_addr),
        .scan_vram (scan_vram),
        .scan_y    (scan_y),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .line_we   (line_we),
        .line_addr (line_addr),
        .line_din  (line_din)
    );

    // Screen flip applies on the display side only
    sprite_line_buffer u_line (
        .clk       (clk),
        .rst       (rst),
        .hs        (hs),
        .flip      (flip),
        .line_we   (line_we),
        .line_addr (line_addr),
        .line_din  (line_din),
        .hdump     (hdump),
        .pxl_cen   (pxl_cen),
        .col_addr  (col_addr)
    );

endmodule

// ==== tb_clock.sv ====
// Testbench clock source with a 10-unit period and a 16-cycle reset
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset released on a rising edge after 16 cycles
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== sprite_gfx_tb.sv ====
// Sprite generator testbench with ROM model, line timing and file-driven checks
module sprite_gfx_tb;
    import sprite_pkg::*;

    localparam int STIM_DEPTH = 256;
    localparam int SCAN_WAIT  = 1200;

    logic       clk;
    logic       rst;
    logic       pxl_cen;
    logic       hs;
    scr_pos_t   vdump;
    scr_pos_t   hdump;
    logic       cpu_rnw;
    cpu_addr_t  cpu_addr;
    byte_t      cpu_dout;
    logic       vram_cs;
    logic       vctrl_cs;
    byte_t      cpu_din;
    rom_addr_t  rom_addr;
    rom_word_t  rom_data = '0;
    logic       rom_ok = 1'b0;
    logic       rom_cs;
    logic       flip;
    col_t       col_addr;

    // Op in bits 35..32, address 31..16, data 15..0
    logic [35:0] stim [0:STIM_DEPTH-1];
    col_t        exp_col [0:511];

    logic [31:0] lfsr_state = 32'h022abbd2;
    int          rom_wait = 0;
    logic        rom_taken = 1'b0;
    rom_addr_t   rom_req_addr = '0;
    int          cycles = 0;
    int          cycle_limit = 1000000;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    int          n_tests = 0;
    int          bad_tests = 0;

    tb_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    sprite_gfx sprite_gfx_inst (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .vdump    (vdump),
        .hdump    (hdump),
        .cpu_rnw  (cpu_rnw),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .vram_cs  (vram_cs),
        .vctrl_cs (vctrl_cs),
        .cpu_din  (cpu_din),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .rom_cs   (rom_cs),
        .flip     (flip),
        .col_addr (col_addr)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    // ROM latency of 1 to 8 cycles
    function automatic int rom_delay();
        int d;
        d = 0;
        for (int i = 0; i < 3; i++) begin
            d = (d << 1) | lfsr_bit();
        end
        return d + 1;
    endfunction

    // ROM model answering with the low 16 address bits twice
    always @(posedge clk) begin
        rom_ok    <= 1'b0;
        rom_taken <= rom_ok;
        if (rom_wait != 0) begin
            // Request held with a steady address until answered
            assert (rom_cs === 1'b1) else begin
                $display("error: time %0t rom_cs got %b expected 1",
                         $time, rom_cs);
                errors++;
                test_errors++;
            end
            assert (rom_addr === rom_req_addr) else begin
                $display("error: time %0t rom_addr got %h expected %h",
                         $time, rom_addr, rom_req_addr);
                errors++;
                test_errors++;
            end
        end
        if (rom_taken) begin
            // Request dropped for a cycle after the data
            assert (rom_cs === 1'b0) else begin
                $display("error: time %0t rom_cs got %b expected 0",
                         $time, rom_cs);
                errors++;
                test_errors++;
            end
        end
        if (rom_wait == 1) begin
            rom_ok   <= 1'b1;
            rom_data <= {rom_addr[15:0], rom_addr[15:0]};
            rom_wait <= 0;
        end else if (rom_wait != 0) begin
            rom_wait <= rom_wait - 1;
        end else if (rom_cs && !rom_ok && !rst) begin
            rom_wait     <= rom_delay();
            rom_req_addr <= rom_addr;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic cpu_write(input logic ctrl, input cpu_addr_t a, input byte_t d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_dout <= d;
        cpu_rnw  <= 1'b0;
        vram_cs  <= ~ctrl;
        vctrl_cs <= ctrl;
        @(posedge clk);
        cpu_rnw  <= 1'b1;
        vram_cs  <= 1'b0;
        vctrl_cs <= 1'b0;
    endtask

    // Data comes back one cycle after the address
    task automatic cpu_read_check(input logic ctrl, input cpu_addr_t a, input byte_t d);
        @(posedge clk);
        cpu_addr <= a;
        cpu_rnw  <= 1'b1;
        vram_cs  <= ~ctrl;
        vctrl_cs <= ctrl;
        @(posedge clk);
        vram_cs  <= 1'b0;
        vctrl_cs <= 1'b0;
        @(posedge clk);
        checks++;
        test_checks++;
        assert (cpu_din === d) else begin
            $display("error: time %0t cpu_din got %h expected %h (addr %h)",
                     $time, cpu_din, d, a);
            errors++;
            test_errors++;
        end
    endtask

    task automatic pulse_hs(input scr_pos_t v);
        @(posedge clk);
        vdump <= v;
        hs    <= 1'b1;
        @(posedge clk);
        hs    <= 1'b0;
    endtask

    // Draw line l into the back half
    task automatic scan_line(input scr_pos_t l);
        pulse_hs(l - 9'd1);
        repeat (SCAN_WAIT) @(posedge clk);
    endtask

    // Swap halves on a blank line and read out all 512 pixels
    task automatic sweep_line(input logic check);
        int h;
        pulse_hs(9'h07f);
        for (h = 0; h <= 512; h++) begin
            @(posedge clk);
            if (h > 0 && check) begin
                checks++;
                test_checks++;
                assert (col_addr === exp_col[h-1]) else begin
                    $display("error: time %0t col_addr at hdump %h got %h expected %h",
                             $time, h - 1, col_addr, exp_col[h-1]);
                    errors++;
                    test_errors++;
                end
            end
            if (h < 512) begin
                hdump   <= scr_pos_t'(h);
                pxl_cen <= 1'b1;
                @(posedge clk);
                pxl_cen <= 1'b0;
            end
        end
        for (h = 0; h < 512; h++) begin
            exp_col[h] = '0;
        end
    endtask

    task automatic finish_test(input int num);
        n_tests++;
        if (test_errors != 0) begin
            bad_tests++;
        end
        $display("test %0d: %0d checks, %0d errors, %s",
                 num, test_checks, test_errors, (test_errors == 0) ? "ok" : "bad");
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int n_ops;
        logic [3:0]  op;
        logic [15:0] a;
        logic [15:0] d;

        pxl_cen  = 1'b0;
        hs       = 1'b0;
        vdump    = '0;
        hdump    = '0;
        cpu_rnw  = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        vram_cs  = 1'b0;
        vctrl_cs = 1'b0;
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim[i] = '0;
        end
        for (int i = 0; i < 512; i++) begin
            exp_col[i] = '0;
        end
        $readmemh("sprite_stim.txt", stim);
        n_ops = 0;
        while (n_ops < STIM_DEPTH && stim[n_ops][35:32] != 4'h0) begin
            n_ops++;
        end
        // Worst case per op is a scan or a full sweep
        cycle_limit = 200 + n_ops * 1300;

        @(negedge rst);
        repeat (2) @(posedge clk);

        for (int i = 0; i < n_ops; i++) begin
            op = stim[i][35:32];
            a  = stim[i][31:16];
            d  = stim[i][15:0];
            case (op)
                4'h1: cpu_write(1'b0, a[12:0], d[7:0]);
                4'h2: cpu_write(1'b1, a[12:0], d[7:0]);
                4'h3: cpu_read_check(1'b0, a[12:0], d[7:0]);
                4'h4: cpu_read_check(1'b1, a[12:0], d[7:0]);
                4'h5: scan_line(a[8:0]);
                4'h6: exp_col[a[8:0]] = d[8:0];
                4'h7: sweep_line(d[0]);
                4'h8: begin
                    // Same y byte for the first a sprites
                    for (int s = 0; s < a; s++) begin
                        cpu_write(1'b1, cpu_addr_t'(s), d[7:0]);
                    end
                end
                4'h9: begin
                    @(posedge clk);
                    checks++;
                    test_checks++;
                    assert (flip === d[0]) else begin
                        $display("error: time %0t flip got %b expected %b",
                                 $time, flip, d[0]);
                        errors++;
                        test_errors++;
                    end
                end
                4'hf: finish_test(d);
                default: begin
                    $display("stimulus line %0d has an unknown operation %h", i, op);
                    errors++;
                end
            endcase
        end

        if (n_tests == 0) begin
            $display("no tests were read from the stimulus file");
            errors++;
        end
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 n_tests, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sprite_stim.txt ====
// op_addr_data: 1 vram wr, 2 vctrl wr, 3 vram rd, 4 vctrl rd, 5 scan line, 6 expected pixel
// 7 sweep (data 1 checks), 8 fill y (addr = count), 9 flip level, f end of test (data = number)
4_0300_0000
1_0005_005a
1_1005_00a5
2_02ff_003c
2_0301_0077
3_0005_005a
3_1005_00a5
4_02ff_003c
4_0301_0077
8_0020_00e0
7_0000_0000
7_0000_0000
f_0000_0001
2_0000_0020
1_0000_0003
1_1000_0000
1_0200_0040
1_1200_0028
5_0025_0000
6_0040_005a
6_0041_0056
6_0044_005a
6_0045_0056
6_0048_005b
6_0049_0056
6_004c_005b
6_004d_0056
7_0000_0001
f_0000_0002
2_0001_0060
1_0001_0003
1_1001_00c0
1_0201_0080
1_1201_0018
5_0062_0000
6_0082_0037
6_0083_003b
6_0086_0037
6_0087_003b
6_008a_0037
6_008b_003a
6_008e_0037
6_008f_003a
7_0000_0001
f_0000_0003
5_0090_0000
7_0000_0001
f_0000_0004
2_0300_0040
9_0000_0001
4_0300_0040
5_0025_0000
6_00bf_005a
6_00be_0056
6_00bb_005a
6_00ba_0056
6_00b7_005b
6_00b6_0056
6_00b3_005b
6_00b2_0056
7_0000_0001
2_0300_0000
9_0000_0000
f_0000_0005
2_0002_00a0
1_0002_0003
1_1002_0000
1_0202_0000
1_1202_0009
2_0003_00a3
1_0003_00f1
1_1003_0000
1_0203_0004
1_1203_0011
5_00a3_0000
6_0100_0016
6_0101_0016
6_0104_0016
6_0105_0022
6_0106_002e
6_0107_0021
6_0108_0017
6_0109_0022
6_010a_002e
6_010b_0021
6_010c_0021
6_010d_0022
6_010e_002e
6_010f_0021
6_0110_0021
6_0111_0022
6_0112_002e
6_0113_0021
7_0000_0001
f_0000_0006

// ==== all.f ====
+incdir+.
sprite_pkg.sv
sprite_cpu_decode.sv
sprite_scan.sv
sprite_line_buffer.sv
sprite_gfx.sv
tb_clock.sv
sprite_gfx_tb.sv
